//--- build.f
hdl/sf3_pkg.sv
hdl/spi_xfer_if.sv
hdl/spi_byte_engine.sv
hdl/flash_cmd_sequencer.sv
hdl/sf3_flash_ctrl.sv
tests/n25q_flash_model.sv
tests/tb_sf3_flash_ctrl.sv

//--- hdl/flash_cmd_sequencer.sv
module flash_cmd_sequencer #(
    parameter int unsigned p_boot_wait_cycles = 4000
) (
    input  logic                 i_ext_spi_clk_x,
    input  logic                 i_srst,
    input  logic                 i_cmd_random_read,
    input  logic                 i_cmd_erase_subsector,
    input  logic                 i_cmd_page_program,
    input  sf3_pkg::t_flash_addr i_address_of_cmd,
    input  sf3_pkg::t_xfer_len   i_len_random_read,
    input  sf3_pkg::t_flash_byte i_wr_data_stream,
    input  logic                 i_wr_data_valid,
    output logic                 o_command_ready,
    output logic                 o_wr_data_ready,
    output sf3_pkg::t_flash_byte o_rd_data_stream,
    output logic                 o_rd_data_valid,
    output sf3_pkg::t_flash_byte o_reg_status,
    output sf3_pkg::t_flash_byte o_reg_flag,
    spi_xfer_if.seq              x
);
    import sf3_pkg::*;

    localparam int c_boot_cnt_bits = $clog2(p_boot_wait_cycles + 1);

    t_seq_state                 state_q;
    logic [c_boot_cnt_bits-1:0] boot_cnt_q;
    logic [2:0]                 byte_idx_q;
    t_xfer_len                  page_cnt_q;
    logic                       prog_q;
    t_flash_addr                addr_q;
    t_xfer_len                  rd_len_q;
    t_flash_byte                status_q;
    t_flash_byte                flag_q;

    t_n25q_opcode hdr_op;
    logic [2:0]   hdr_last;
    logic         hdr_state;
    logic         hdr_done;
    t_seq_state   hdr_next;
    logic         cmd_accept;

    // ----------------------------------------------------------------------
    // Transaction header of the current state
    // ----------------------------------------------------------------------
    always_comb begin
        hdr_state      = 1'b1;
        hdr_op         = OP_READ_STATUS;
        hdr_last       = 3'd0;
        hdr_next       = ST_STATUS_WAIT;
        x.tx_len       = t_xfer_len'(1);
        x.rx_len       = '0;
        x.dummy_clocks = '0;
        case (state_q)
            ST_STATUS_POLL: begin
                x.rx_len = t_xfer_len'(1);
            end
            ST_FLAG_POLL: begin
                hdr_op   = OP_READ_FLAG;
                hdr_next = ST_FLAG_WAIT;
                x.rx_len = t_xfer_len'(1);
            end
            ST_WREN: begin
                hdr_op   = OP_WRITE_ENABLE;
                hdr_next = ST_WREN_WAIT;
            end
            ST_READ: begin
                hdr_op         = OP_READ_4B;
                hdr_next       = ST_READ_DATA;
                hdr_last       = 3'(c_addr_bytes);
                x.tx_len       = t_xfer_len'(1 + c_addr_bytes);
                x.rx_len       = rd_len_q;
                x.dummy_clocks = 4'(c_read_dummy_clocks);
            end
            ST_ERASE: begin
                hdr_op   = OP_ERASE_SUB_4B;
                hdr_next = ST_XFER_WAIT;
                hdr_last = 3'(c_addr_bytes);
                x.tx_len = t_xfer_len'(1 + c_addr_bytes);
            end
            ST_PROGRAM: begin
                hdr_op   = OP_PROGRAM_4B;
                hdr_next = ST_PROGRAM_DATA;
                hdr_last = 3'(c_addr_bytes);
                x.tx_len = t_xfer_len'(1 + c_addr_bytes + c_page_bytes);
            end
            default: begin
                hdr_state = 1'b0;
            end
        endcase
    end

    // Opcode goes out at go, the address follows MSB first
    assign x.go     = hdr_state && (byte_idx_q == 3'd0) && x.idle;
    assign hdr_done = hdr_state && x.tx_take && (byte_idx_q == hdr_last);

    always_comb begin
        if (state_q == ST_PROGRAM_DATA) begin
            x.tx_valid = i_wr_data_valid;
            x.tx_data  = i_wr_data_stream;
        end else begin
            x.tx_valid = hdr_state;
            x.tx_data  = (byte_idx_q == 3'd0) ? t_flash_byte'(hdr_op) : addr_q[31:24];
        end
    end

    assign cmd_accept = (state_q == ST_IDLE) &&
                        (i_cmd_random_read || i_cmd_erase_subsector || i_cmd_page_program);

    // ----------------------------------------------------------------------
    // State machine
    // ----------------------------------------------------------------------
    always_ff @(posedge i_ext_spi_clk_x) begin
        if (i_srst) begin
            state_q    <= ST_BOOT_WAIT;
            boot_cnt_q <= '0;
            byte_idx_q <= '0;
            page_cnt_q <= '0;
            prog_q     <= 1'b0;
            status_q   <= '0;
            flag_q     <= '0;
        end else begin
            if (hdr_done) begin
                byte_idx_q <= '0;
                state_q    <= hdr_next;
            end else if (hdr_state && x.tx_take) begin
                byte_idx_q <= byte_idx_q + 3'd1;
            end

            case (state_q)
                ST_BOOT_WAIT: begin
                    if (boot_cnt_q == c_boot_cnt_bits'(p_boot_wait_cycles - 1)) begin
                        state_q <= ST_STATUS_POLL;
                    end else begin
                        boot_cnt_q <= boot_cnt_q + 1'b1;
                    end
                end
                ST_STATUS_WAIT: begin
                    if (x.rx_valid) begin
                        status_q <= x.rx_data;
                    end
                    // Busy bit 0 keeps the status poll going
                    if (x.idle) begin
                        state_q <= status_q[0] ? ST_STATUS_POLL : ST_FLAG_POLL;
                    end
                end
                ST_FLAG_WAIT: begin
                    if (x.rx_valid) begin
                        flag_q <= x.rx_data;
                    end
                    if (x.idle) begin
                        state_q <= flag_q[7] ? ST_IDLE : ST_FLAG_POLL;
                    end
                end
                ST_IDLE: begin
                    // Read wins over erase, erase over program
                    if (i_cmd_random_read) begin
                        state_q <= ST_READ;
                    end else if (i_cmd_erase_subsector) begin
                        state_q <= ST_WREN;
                        prog_q  <= 1'b0;
                    end else if (i_cmd_page_program) begin
                        state_q <= ST_WREN;
                        prog_q  <= 1'b1;
                    end
                end
                ST_READ_DATA: begin
                    if (x.idle) begin
                        state_q <= ST_IDLE;
                    end
                end
                ST_WREN_WAIT: begin
                    if (x.idle) begin
                        state_q <= prog_q ? ST_PROGRAM : ST_ERASE;
                    end
                end
                ST_PROGRAM_DATA: begin
                    if (x.tx_take) begin
                        if (page_cnt_q == t_xfer_len'(c_page_bytes - 1)) begin
                            page_cnt_q <= '0;
                            state_q    <= ST_XFER_WAIT;
                        end else begin
                            page_cnt_q <= page_cnt_q + 1'b1;
                        end
                    end
                end
                ST_XFER_WAIT: begin
                    if (x.idle) begin
                        state_q <= ST_FLAG_POLL;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Command payload, the address shifts out one byte per take
    always_ff @(posedge i_ext_spi_clk_x) begin
        if (cmd_accept) begin
            addr_q   <= i_address_of_cmd;
            rd_len_q <= i_len_random_read;
        end else if (hdr_state && x.tx_take && (byte_idx_q != 3'd0)) begin
            addr_q <= {addr_q[23:0], 8'h00};
        end
    end

    assign o_command_ready  = (state_q == ST_IDLE);
    assign o_wr_data_ready  = (state_q == ST_PROGRAM_DATA) && x.tx_take;
    assign o_rd_data_stream = x.rx_data;
    assign o_rd_data_valid  = (state_q == ST_READ_DATA) && x.rx_valid;
    assign o_reg_status     = status_q;
    assign o_reg_flag       = flag_q;

endmodule

//--- hdl/sf3_flash_ctrl.sv
module sf3_flash_ctrl #(
    parameter int unsigned p_boot_wait_cycles = 4000
) (
    input  logic                 i_ext_spi_clk_x,
    input  logic                 i_srst,
    // Command interface
    input  logic                 i_cmd_random_read,
    input  logic                 i_cmd_erase_subsector,
    input  logic                 i_cmd_page_program,
    input  sf3_pkg::t_flash_addr i_address_of_cmd,
    input  sf3_pkg::t_xfer_len   i_len_random_read,
    output logic                 o_command_ready,
    // Write and read streams
    input  sf3_pkg::t_flash_byte i_wr_data_stream,
    input  logic                 i_wr_data_valid,
    output logic                 o_wr_data_ready,
    output sf3_pkg::t_flash_byte o_rd_data_stream,
    output logic                 o_rd_data_valid,
    // Last register values read from the flash
    output sf3_pkg::t_flash_byte o_reg_status,
    output sf3_pkg::t_flash_byte o_reg_flag,
    // SPI pins
    output logic                 o_spi_sck,
    output logic                 o_spi_cs_n,
    output logic                 o_spi_mosi,
    input  logic                 i_spi_miso
);

    spi_xfer_if x ();

    flash_cmd_sequencer #(
        .p_boot_wait_cycles(p_boot_wait_cycles)
    ) u_seq (
        .i_ext_spi_clk_x      (i_ext_spi_clk_x),
        .i_srst               (i_srst),
        .i_cmd_random_read    (i_cmd_random_read),
        .i_cmd_erase_subsector(i_cmd_erase_subsector),
        .i_cmd_page_program   (i_cmd_page_program),
        .i_address_of_cmd     (i_address_of_cmd),
        .i_len_random_read    (i_len_random_read),
        .i_wr_data_stream     (i_wr_data_stream),
        .i_wr_data_valid      (i_wr_data_valid),
        .o_command_ready      (o_command_ready),
        .o_wr_data_ready      (o_wr_data_ready),
        .o_rd_data_stream     (o_rd_data_stream),
        .o_rd_data_valid      (o_rd_data_valid),
        .o_reg_status         (o_reg_status),
        .o_reg_flag           (o_reg_flag),
        .x                    (x.seq)
    );

    spi_byte_engine u_eng (
        .i_ext_spi_clk_x(i_ext_spi_clk_x),
        .i_srst         (i_srst),
        .i_spi_miso     (i_spi_miso),
        .o_spi_sck      (o_spi_sck),
        .o_spi_cs_n     (o_spi_cs_n),
        .o_spi_mosi     (o_spi_mosi),
        .x              (x.eng)
    );

endmodule

//--- hdl/sf3_pkg.sv
package sf3_pkg;

    // ----------------------------------------------------------------------
    // N25Q command set used by the controller
    // ----------------------------------------------------------------------
    typedef enum logic [7:0] {
        OP_WRITE_ENABLE = 8'h06,
        OP_READ_STATUS  = 8'h05,
        OP_READ_FLAG    = 8'h70,
        OP_READ_4B      = 8'h0C,
        OP_ERASE_SUB_4B = 8'h21,
        OP_PROGRAM_4B   = 8'h12
    } t_n25q_opcode;

    // ----------------------------------------------------------------------
    // Command sequencer states
    // ----------------------------------------------------------------------
    typedef enum logic [4:0] {
        ST_BOOT_WAIT,
        ST_STATUS_POLL,
        ST_STATUS_WAIT,
        ST_FLAG_POLL,
        ST_FLAG_WAIT,
        ST_IDLE,
        ST_READ,
        ST_READ_DATA,
        ST_WREN,
        ST_WREN_WAIT,
        ST_ERASE,
        ST_PROGRAM,
        ST_PROGRAM_DATA,
        ST_XFER_WAIT
    } t_seq_state;

    // ----------------------------------------------------------------------
    // Flash geometry and access constants
    // ----------------------------------------------------------------------
    localparam integer c_addr_bytes        = 4;
    localparam integer c_page_bytes        = 256;
    localparam integer c_subsector_bytes   = 4096;
    localparam integer c_read_dummy_clocks = 8;

    // Opcode, address and one full page fit in a phase count
    typedef logic [8:0]  t_xfer_len;
    typedef logic [31:0] t_flash_addr;
    typedef logic [7:0]  t_flash_byte;

endpackage

//--- hdl/spi_byte_engine.sv
module spi_byte_engine (
    input  logic i_ext_spi_clk_x,
    input  logic i_srst,
    input  logic i_spi_miso,
    output logic o_spi_sck,
    output logic o_spi_cs_n,
    output logic o_spi_mosi,
    spi_xfer_if.eng x
);
    import sf3_pkg::*;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_SEND,
        PH_DUMMY,
        PH_RECV,
        PH_RELEASE
    } t_phase;

    t_phase      ph_q;
    logic        sck_q;
    logic        cs_n_q;
    logic        armed_q;
    logic [2:0]  bit_q;
    t_xfer_len   tx_left_q;
    t_xfer_len   rx_left_q;
    logic [3:0]  dmy_left_q;
    logic        rx_valid_q;
    t_flash_byte tx_sh_q;
    t_flash_byte rx_sh_q;

    t_xfer_len   tx_left;
    t_xfer_len   rx_left;
    logic [3:0]  dmy_left;
    logic        active;
    logic        step;
    logic        in_byte;

    // While idle the counts come straight from the request
    assign tx_left  = (ph_q == PH_IDLE) ? x.tx_len : tx_left_q;
    assign rx_left  = (ph_q == PH_IDLE) ? x.rx_len : rx_left_q;
    assign dmy_left = (ph_q == PH_IDLE) ? x.dummy_clocks : dmy_left_q;

    assign active = (ph_q == PH_SEND) || (ph_q == PH_DUMMY) || (ph_q == PH_RECV);

    // A new SCK low half begins at this edge, or a stalled byte is retried
    assign step    = (ph_q == PH_IDLE) ? x.go : active && (sck_q || !armed_q);
    assign in_byte = armed_q && (ph_q != PH_DUMMY) && (bit_q != 3'd0);

    assign x.tx_take  = step && !in_byte && (tx_left != '0) && x.tx_valid;
    assign x.rx_data  = rx_sh_q;
    assign x.rx_valid = rx_valid_q;
    assign x.idle     = (ph_q == PH_IDLE);

    assign o_spi_sck  = sck_q;
    assign o_spi_cs_n = cs_n_q;
    assign o_spi_mosi = tx_sh_q[7];

    // ----------------------------------------------------------------------
    // Phase control and SCK generation
    // ----------------------------------------------------------------------
    always_ff @(posedge i_ext_spi_clk_x) begin
        if (i_srst) begin
            ph_q       <= PH_IDLE;
            sck_q      <= 1'b0;
            cs_n_q     <= 1'b1;
            armed_q    <= 1'b0;
            bit_q      <= '0;
            tx_left_q  <= '0;
            rx_left_q  <= '0;
            dmy_left_q <= '0;
            rx_valid_q <= 1'b0;
        end else begin
            rx_valid_q <= 1'b0;
            if (ph_q == PH_RELEASE) begin
                ph_q <= PH_IDLE;
            end else if (step) begin
                sck_q      <= 1'b0;
                cs_n_q     <= 1'b0;
                tx_left_q  <= tx_left;
                rx_left_q  <= rx_left;
                dmy_left_q <= dmy_left;
                if (in_byte) begin
                    bit_q <= bit_q - 3'd1;
                end else if (tx_left != '0) begin
                    // Without tx_valid SCK stays low and the load is retried
                    ph_q    <= PH_SEND;
                    bit_q   <= 3'd7;
                    armed_q <= x.tx_valid;
                    if (x.tx_valid) begin
                        tx_left_q <= tx_left - 1'b1;
                    end
                end else if (dmy_left != '0) begin
                    ph_q       <= PH_DUMMY;
                    armed_q    <= 1'b1;
                    dmy_left_q <= dmy_left - 1'b1;
                end else if (rx_left != '0) begin
                    ph_q      <= PH_RECV;
                    armed_q   <= 1'b1;
                    bit_q     <= 3'd7;
                    rx_left_q <= rx_left - 1'b1;
                end else begin
                    ph_q    <= PH_RELEASE;
                    armed_q <= 1'b0;
                    cs_n_q  <= 1'b1;
                end
            end else if (armed_q) begin
                // Rising SCK edge, the flash sees MOSI and MISO is captured
                sck_q <= 1'b1;
                if (ph_q == PH_RECV) begin
                    rx_valid_q <= (bit_q == 3'd0);
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Shift registers, MSB first
    // ----------------------------------------------------------------------
    always_ff @(posedge i_ext_spi_clk_x) begin
        if (x.tx_take) begin
            tx_sh_q <= x.tx_data;
        end else if (step && in_byte && (ph_q == PH_SEND)) begin
            tx_sh_q <= {tx_sh_q[6:0], 1'b0};
        end
        if (!step && armed_q && (ph_q == PH_RECV)) begin
            rx_sh_q <= {rx_sh_q[6:0], i_spi_miso};
        end
    end

endmodule

//--- hdl/spi_xfer_if.sv
interface spi_xfer_if;
    import sf3_pkg::*;

    // Request, sampled by the engine together with go
    logic        go;
    t_xfer_len   tx_len;
    t_xfer_len   rx_len;
    logic [3:0]  dummy_clocks;

    // Transmit bytes, one per tx_take
    t_flash_byte tx_data;
    logic        tx_valid;
    logic        tx_take;

    // Receive bytes and engine status
    t_flash_byte rx_data;
    logic        rx_valid;
    logic        idle;

    modport seq (
        output go, tx_len, rx_len, dummy_clocks, tx_data, tx_valid,
        input  tx_take, rx_data, rx_valid, idle
    );

    modport eng (
        input  go, tx_len, rx_len, dummy_clocks, tx_data, tx_valid,
        output tx_take, rx_data, rx_valid, idle
    );

endinterface

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; the exit status is the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
    --top-module tb_sf3_flash_ctrl --Mdir obj_dir -f build.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/Vtb_sf3_flash_ctrl
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation run failed with status $sim_status"
    exit $sim_status
fi

exit 0

//--- tests/n25q_flash_model.sv
module n25q_flash_model (
    input  logic i_spi_sck,
    input  logic i_spi_cs_n,
    input  logic i_spi_mosi,
    output logic o_spi_miso,
    output int   o_cmd_count,
    output logic o_protocol_error
);
    timeunit 1ns;
    timeprecision 100ps;
    import sf3_pkg::*;

    // Read data starts after the opcode, address and dummy clocks
    localparam int c_read_start = (1 + c_addr_bytes) * 8 + c_read_dummy_clocks;

    logic [7:0]   mem [logic [31:0]];
    t_flash_byte  page_buf [c_page_bytes];
    t_flash_byte  shift_in = '0;
    t_flash_byte  reply = '0;
    t_n25q_opcode opcode = OP_READ_STATUS;
    t_flash_addr  addr = '0;
    int           bit_cnt = 0;
    int           data_cnt = 0;
    int           status_polls = 0;
    int           flag_busy = 0;
    int           cmd_count = 0;
    logic         wel = 1'b0;
    logic         cs_q = 1'b1;
    logic         sck_q = 1'b0;
    logic         miso_q = 1'b0;
    logic         error_q = 1'b0;

    assign o_spi_miso       = miso_q;
    assign o_cmd_count      = cmd_count;
    assign o_protocol_error = error_q;

    function automatic t_flash_byte mem_byte(input t_flash_addr a);
        return mem.exists(a) ? mem[a] : 8'hFF;
    endfunction

    // ----------------------------------------------------------------------
    // Rising SCK shifts MOSI in MSB first
    // ----------------------------------------------------------------------
    task automatic take_mosi_bit();
        int byte_no;
        shift_in = {shift_in[6:0], i_spi_mosi};
        bit_cnt++;
        if (bit_cnt % 8 == 0) begin
            byte_no = bit_cnt / 8 - 1;
            if (byte_no == 0) begin
                opcode = t_n25q_opcode'(shift_in);
                if (opcode == OP_READ_STATUS) begin
                    // Busy for the first three polls after power-up
                    reply = (status_polls < 3) ? 8'h01 : 8'h00;
                    status_polls++;
                end else if (opcode == OP_READ_FLAG) begin
                    reply = (flag_busy > 0) ? 8'h00 : 8'h80;
                    if (flag_busy > 0) begin
                        flag_busy--;
                    end
                end else if ((status_polls <= 3) || (flag_busy > 0)) begin
                    // Only register reads are legal until both busy phases are over
                    $display("flash model: %s arrived while the device was busy",
                             opcode.name());
                    error_q = 1'b1;
                end
            end else if (byte_no <= c_addr_bytes) begin
                addr = {addr[23:0], shift_in};
            end else if (opcode == OP_PROGRAM_4B) begin
                if (data_cnt < c_page_bytes) begin
                    page_buf[data_cnt] = shift_in;
                end
                data_cnt++;
            end
        end
    endtask

    // Falling SCK drives the next reply bit
    task automatic drive_miso_bit();
        int          idx;
        t_flash_byte data;
        if ((opcode == OP_READ_STATUS || opcode == OP_READ_FLAG) && bit_cnt >= 8) begin
            miso_q = reply[7 - ((bit_cnt - 8) % 8)];
        end else if (opcode == OP_READ_4B && bit_cnt >= c_read_start) begin
            idx    = bit_cnt - c_read_start;
            data   = mem_byte(addr + t_flash_addr'(idx / 8));
            miso_q = data[7 - idx % 8];
        end
    endtask

    // ----------------------------------------------------------------------
    // The command takes effect when chip select is released
    // ----------------------------------------------------------------------
    task automatic finish_command();
        t_flash_addr a;
        case (opcode)
            OP_WRITE_ENABLE: wel = 1'b1;
            OP_READ_4B: cmd_count++;
            OP_ERASE_SUB_4B, OP_PROGRAM_4B: begin
                if (!wel) begin
                    $display("flash model: %s arrived without write enable", opcode.name());
                    error_q = 1'b1;
                end else if (opcode == OP_ERASE_SUB_4B) begin
                    for (int i = 0; i < c_subsector_bytes; i++) begin
                        a = (addr & ~t_flash_addr'(c_subsector_bytes - 1)) + t_flash_addr'(i);
                        if (mem.exists(a)) begin
                            mem.delete(a);
                        end
                    end
                end else if (data_cnt != c_page_bytes) begin
                    $display("flash model: page program carried %0d data bytes", data_cnt);
                    error_q = 1'b1;
                end else begin
                    // Programming only clears bits and wraps inside the page
                    for (int i = 0; i < c_page_bytes; i++) begin
                        a = {addr[31:8], addr[7:0] + 8'(i)};
                        mem[a] = mem_byte(a) & page_buf[i];
                    end
                end
                wel       = 1'b0;
                flag_busy = 2;
                cmd_count++;
            end
            default: begin
            end
        endcase
    endtask

    always @(i_spi_sck or i_spi_cs_n) begin
        if (!i_spi_cs_n && cs_q) begin
            bit_cnt  = 0;
            data_cnt = 0;
            opcode   = t_n25q_opcode'(8'h00);
        end
        if (!i_spi_cs_n && i_spi_sck && !sck_q) begin
            take_mosi_bit();
        end
        if (!i_spi_cs_n && !i_spi_sck && sck_q) begin
            drive_miso_bit();
        end
        if (i_spi_cs_n && !cs_q) begin
            finish_command();
        end
        cs_q  = i_spi_cs_n;
        sck_q = i_spi_sck;
    end

endmodule

//--- tests/tb_sf3_flash_ctrl.sv
module tb_sf3_flash_ctrl;
    timeunit 1ns;
    timeprecision 100ps;
    import sf3_pkg::*;

    localparam int          c_boot_cycles  = 50;
    localparam int          c_cmd_timeout  = 20000;
    localparam int          c_region_bytes = 2 * c_subsector_bytes;
    localparam t_flash_addr c_region_base  = 32'h0123_0000;
    localparam t_flash_addr c_sub_mask     = ~t_flash_addr'(c_subsector_bytes - 1);

    typedef enum int {
        CMD_READ,
        CMD_ERASE,
        CMD_PROGRAM
    } t_cmd_kind;

    logic        i_ext_spi_clk_x;
    logic        i_srst;
    logic        i_cmd_random_read;
    logic        i_cmd_erase_subsector;
    logic        i_cmd_page_program;
    t_flash_addr i_address_of_cmd;
    t_xfer_len   i_len_random_read;
    logic        o_command_ready;
    t_flash_byte i_wr_data_stream;
    logic        i_wr_data_valid;
    logic        o_wr_data_ready;
    t_flash_byte o_rd_data_stream;
    logic        o_rd_data_valid;
    t_flash_byte o_reg_status;
    t_flash_byte o_reg_flag;
    logic        o_spi_sck;
    logic        o_spi_cs_n;
    logic        o_spi_mosi;
    logic        i_spi_miso;

    int          seed;
    int          issued;
    int          flash_cmd_count;
    logic        flash_error;
    t_flash_byte ref_mem [t_flash_addr];
    t_flash_byte wr_buf [c_page_bytes];

    sf3_flash_ctrl #(
        .p_boot_wait_cycles(c_boot_cycles)
    ) uut (.*);

    n25q_flash_model flash (
        .i_spi_sck       (o_spi_sck),
        .i_spi_cs_n      (o_spi_cs_n),
        .i_spi_mosi      (o_spi_mosi),
        .o_spi_miso      (i_spi_miso),
        .o_cmd_count     (flash_cmd_count),
        .o_protocol_error(flash_error)
    );

    initial begin
        i_ext_spi_clk_x = 1'b0;
        forever #50 i_ext_spi_clk_x = ~i_ext_spi_clk_x;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped after a failed check");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("error at %0t ns: %s expected 0x%0h, actual 0x%0h",
                                        $time, name, expected, actual));
        end
    endtask

    function automatic t_flash_byte ref_byte(input t_flash_addr a);
        return ref_mem.exists(a) ? ref_mem[a] : 8'hFF;
    endfunction

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic wait_for_ready(input int limit);
        int cycles;
        cycles = 0;
        while (!o_command_ready) begin
            @(negedge i_ext_spi_clk_x);
            cycles++;
            if (cycles > limit) begin
                stop_with_failure("timeout: o_command_ready did not rise");
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // One command from strobe to o_command_ready with its data streams
    // ----------------------------------------------------------------------
    task automatic run_command(input t_cmd_kind kind, input t_flash_addr addr, input int len);
        int          cycles;
        int          rd_cnt;
        int          wr_idx;
        logic        done;
        t_flash_addr a;
        cycles = 0;
        rd_cnt = 0;
        wr_idx = 0;
        done   = 1'b0;
        wait_for_ready(c_cmd_timeout);
        i_address_of_cmd      = addr;
        i_len_random_read     = t_xfer_len'(len);
        i_cmd_random_read     = (kind == CMD_READ);
        i_cmd_erase_subsector = (kind == CMD_ERASE);
        i_cmd_page_program    = (kind == CMD_PROGRAM);
        issued++;
        while (!done) begin
            @(negedge i_ext_spi_clk_x);
            cycles++;
            if (cycles > c_cmd_timeout) begin
                stop_with_failure("timeout: command did not finish");
            end
            if (cycles == 1) begin
                check_value("o_command_ready", 32'd0, 32'(o_command_ready));
            end
            if (o_rd_data_valid) begin
                if (kind == CMD_READ) begin
                    check_value("o_rd_data_stream", 32'(ref_byte(addr + t_flash_addr'(rd_cnt))),
                                32'(o_rd_data_stream));
                end
                rd_cnt++;
            end
            done = o_command_ready;
            // Strobes while busy have to be ignored by the DUT
            if (!done && rand_below(8) == 0) begin
                {i_cmd_random_read, i_cmd_erase_subsector, i_cmd_page_program} = 3'(rand_below(8));
                i_address_of_cmd = t_flash_addr'($random(seed));
            end else begin
                {i_cmd_random_read, i_cmd_erase_subsector, i_cmd_page_program} = 3'b000;
            end
            // Write data is offered during every command, only a program may take it
            i_wr_data_valid  = !done && (wr_idx < c_page_bytes) && (rand_below(4) != 0);
            i_wr_data_stream = wr_buf[wr_idx % c_page_bytes];
            if (!done) begin
                // Ready follows valid combinationally and settles just after the drive
                #1;
                if (i_wr_data_valid && o_wr_data_ready) begin
                    wr_idx++;
                end
            end
        end
        check_value("read byte count", (kind == CMD_READ) ? len : 0, rd_cnt);
        check_value("write byte count", (kind == CMD_PROGRAM) ? c_page_bytes : 0, wr_idx);
        if (flash_error) begin
            stop_with_failure("flash model reported an illegal command sequence");
        end
        if (kind != CMD_READ) begin
            check_value("o_reg_flag[7]", 32'd1, 32'(o_reg_flag[7]));
        end
        if (kind == CMD_ERASE) begin
            for (int i = 0; i < c_subsector_bytes; i++) begin
                a = (addr & c_sub_mask) + t_flash_addr'(i);
                if (ref_mem.exists(a)) begin
                    ref_mem.delete(a);
                end
            end
        end else if (kind == CMD_PROGRAM) begin
            for (int i = 0; i < c_page_bytes; i++) begin
                a = addr + t_flash_addr'(i);
                ref_mem[a] = ref_byte(a) & wr_buf[i];
            end
        end
    endtask

    initial begin
        int          kind_sel;
        t_flash_addr addr;
        seed                  = 32'hd5b1;
        issued                = 0;
        i_srst                = 1'b1;
        i_cmd_random_read     = 1'b0;
        i_cmd_erase_subsector = 1'b0;
        i_cmd_page_program    = 1'b0;
        i_address_of_cmd      = '0;
        i_len_random_read     = '0;
        i_wr_data_stream      = '0;
        i_wr_data_valid       = 1'b0;
        repeat (8) @(negedge i_ext_spi_clk_x);
        check_value("o_spi_cs_n", 32'd1, 32'(o_spi_cs_n));
        check_value("o_spi_sck", 32'd0, 32'(o_spi_sck));
        check_value("o_command_ready", 32'd0, 32'(o_command_ready));
        check_value("o_rd_data_valid", 32'd0, 32'(o_rd_data_valid));
        check_value("o_wr_data_ready", 32'd0, 32'(o_wr_data_ready));
        i_srst = 1'b0;

        // Boot delay plus status and flag polling
        wait_for_ready(5000);
        check_value("o_reg_status", 32'h00, 32'(o_reg_status));
        check_value("o_reg_flag[7]", 32'd1, 32'(o_reg_flag[7]));

        for (int n = 0; n < 20; n++) begin
            kind_sel = rand_below(5);
            if (kind_sel < 2) begin
                addr = c_region_base + t_flash_addr'(rand_below(c_region_bytes));
                run_command(CMD_READ, addr, 1 + rand_below(c_page_bytes));
            end else if (kind_sel == 2) begin
                addr = c_region_base + t_flash_addr'(rand_below(c_region_bytes));
                run_command(CMD_ERASE, addr, 0);
                addr = (addr & c_sub_mask) + t_flash_addr'(rand_below(16) * c_page_bytes);
                run_command(CMD_READ, addr, c_page_bytes);
            end else begin
                for (int i = 0; i < c_page_bytes; i++) begin
                    wr_buf[i] = t_flash_byte'($random(seed));
                end
                addr = c_region_base +
                       t_flash_addr'(rand_below(c_region_bytes / c_page_bytes) * c_page_bytes);
                run_command(CMD_PROGRAM, addr, 0);
                run_command(CMD_READ, addr, c_page_bytes);
            end
        end

        check_value("flash command count", 32'(issued), 32'(flash_cmd_count));
        $display("Simulation passed");
        $finish;
    end

endmodule
